// ==== bench/eth_pcs_tb.sv ====
// Self-checking testbench that runs a stimulus table on the PCS top with serdes TX looped to RX
`timescale 1ns/1ps

module eth_pcs_tb;
    import eth_pcs_pkg::*;

    typedef enum {E_RD, E_WR, E_TX, E_LOOP, E_BAD, E_LOCK} entry_kind_e;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic [63:0] txd;
    logic [7:0]  txc;
    logic [1:0]  tx_hdr;
    logic [63:0] tx_pl;
    logic [1:0]  rx_hdr;
    logic [63:0] rxd;
    logic [7:0]  rxc;
    logic        lock;
    logic        corrupt;

    // Reference TX pipeline with one register per DUT stage
    logic        m_loop;
    logic [1:0]  m_enc_hdr;
    logic [63:0] m_enc_pl;
    logic [57:0] m_state;
    logic [1:0]  m_tx_hdr;
    logic [63:0] m_tx_pl;
    logic [65:0] m_blk;
    logic [63:0] m_scr;

    entry_kind_e tab_kind[$];
    int          tab_arg[$];
    logic [63:0] tab_exp[$];
    logic [31:0] lfsr_q = 32'h082b_007a;
    int          cycles = 0;
    int          limit;

    // Serdes loop with a header corruption mux
    assign rx_hdr = corrupt ? 2'b11 : tx_hdr;

    eth_pcs_top dut0 (
        .wb_i(clk), .arst_n_i(rst_n),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
        .xgmii_txd_i(txd), .xgmii_txc_i(txc),
        .serdes_tx_hdr_o(tx_hdr), .serdes_tx_payload_o(tx_pl),
        .serdes_rx_hdr_i(rx_hdr), .serdes_rx_payload_i(tx_pl),
        .xgmii_rxd_o(rxd), .xgmii_rxc_o(rxc), .block_lock_o(lock)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function logic lfsr_bit();
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        return lfsr_q[0];
    endfunction

    function logic [63:0] random_word();
        logic [63:0] w;
        for (int i = 0; i < 64; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    // 64b/66b encoding of one XGMII word as {header, payload}
    function automatic logic [65:0] encode_block(input logic [63:0] d, input logic [7:0] c);
        logic idle;
        idle = (d == {8{XGMII_IDLE}});
        if (c == 8'h00) begin
            return {HDR_DATA, d};
        end
        if (c == 8'hFF && idle) begin
            return {HDR_CTRL, {8{PCS_IDLE_CODE}}, BT_CTRL_ONLY};
        end
        return {HDR_CTRL, {8{PCS_ERROR_CODE}}, BT_CTRL_ONLY};
    endfunction

    // Output bit is input XOR taps at 39 and 58 bits back
    function automatic logic [63:0] scramble_word(input logic [57:0] st, input logic [63:0] d);
        logic [63:0] o;
        logic [121:0] hist;
        hist = {64'd0, st};
        for (int i = 0; i < 64; i++) begin
            o[i] = d[i] ^ hist[38] ^ hist[57];
            hist = {hist[120:0], o[i]};
        end
        return o;
    endfunction

    // State holds the last 58 line bits with the newest in bit 0
    function automatic logic [57:0] scramble_state(input logic [63:0] o);
        logic [57:0] s;
        for (int k = 0; k < 58; k++) begin
            s[k] = o[63 - k];
        end
        return s;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_loop    <= 1'b0;
            m_enc_hdr <= HDR_CTRL;
            m_enc_pl  <= {{8{PCS_IDLE_CODE}}, BT_CTRL_ONLY};
            m_state   <= '1;
            m_tx_hdr  <= HDR_CTRL;
            m_tx_pl   <= '0;
        end else begin
            if (wb_cyc && wb_stb && wb_we && {wb_adr[7:2], 2'b00} == REG_CONTROL) begin
                m_loop <= wb_dat[CTRL_LOOPBACK_BIT];
            end
            // Loopback feeds back what the receiver delivered
            m_blk     = m_loop ? encode_block(rxd, rxc) : encode_block(txd, txc);
            m_scr     = scramble_word(m_state, m_enc_pl);
            m_enc_hdr <= m_blk[65:64];
            m_enc_pl  <= m_blk[63:0];
            m_tx_hdr  <= m_enc_hdr;
            m_tx_pl   <= m_scr;
            m_state   <= scramble_state(m_scr);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run exceeded %0d cycles", limit);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic add(input entry_kind_e k, input int arg, input logic [63:0] exp);
        tab_kind.push_back(k);
        tab_arg.push_back(arg);
        tab_exp.push_back(exp);
    endtask

    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat = dat;
        check("wb_ack_o", wb_ack, 0);
        step();
        // Ack and read data arrive one edge after the request
        check("wb_ack_o", wb_ack, 1);
        rdata  = wb_rdat;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        step();
        check("wb_ack_o", wb_ack, 0);
    endtask

    task automatic check_tx();
        check("serdes_tx_hdr_o", tx_hdr, m_tx_hdr);
        check("serdes_tx_payload_o", tx_pl, m_tx_pl);
    endtask

    // Word type 0 is data, 1 is idle and 2 is mixed control
    task automatic send_word(input int wtype);
        logic [63:0] w;
        logic [63:0] exp_d;
        logic [7:0]  exp_c;
        w = random_word();
        case (wtype)
            0: begin
                txd   = w;
                txc   = 8'h00;
                exp_d = w;
                exp_c = 8'h00;
            end
            1: begin
                txd   = {8{XGMII_IDLE}};
                txc   = 8'hFF;
                exp_d = {8{XGMII_IDLE}};
                exp_c = 8'hFF;
            end
            default: begin
                txd   = w;
                txc   = 8'h0F;
                exp_d = {8{XGMII_ERROR}};
                exp_c = 8'hFF;
            end
        endcase
        step();
        txd = {8{XGMII_IDLE}};
        txc = 8'hFF;
        step();
        check_tx();
        repeat (3) step();
        check("xgmii_rxd_o", rxd, exp_d);
        check("xgmii_rxc_o", rxc, exp_c);
    endtask

    task automatic wait_lock(input logic exp);
        int n;
        n = 0;
        while (lock !== exp && n < 100) begin
            step();
            n++;
        end
        if (lock !== exp) begin
            $display("Block lock did not reach %0b within 100 cycles", exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        rst_n   = 1'b0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = '0;
        wb_dat  = '0;
        txd     = {8{XGMII_IDLE}};
        txc     = 8'hFF;
        corrupt = 1'b0;
        limit   = 0;

        add(E_RD, REG_ID, PCS_ID_VALUE);
        add(E_RD, 8'h10, 0);
        add(E_WR, REG_CONTROL, 32'hFFFF_FFFC);
        add(E_RD, REG_CONTROL, 0);
        add(E_LOCK, 0, 1);
        add(E_RD, REG_STATUS, 1);
        add(E_TX, 1, 0);
        add(E_TX, 0, 0);
        add(E_TX, 2, 0);
        add(E_TX, 0, 0);
        add(E_BAD, 16, 0);
        add(E_RD, REG_STATUS, 0);
        add(E_LOCK, 0, 1);
        add(E_RD, REG_STATUS, 1);
        add(E_WR, REG_ERR_COUNT, 0);
        add(E_TX, 2, 0);
        add(E_TX, 0, 0);
        add(E_TX, 2, 0);
        add(E_TX, 1, 0);
        add(E_RD, REG_ERR_COUNT, 2);
        add(E_WR, REG_ERR_COUNT, 32'h1234);
        add(E_RD, REG_ERR_COUNT, 0);
        add(E_WR, REG_CONTROL, 32'h2);
        add(E_RD, REG_CONTROL, 32'h2);
        add(E_LOOP, 20, 0);
        add(E_WR, REG_CONTROL, 0);
        add(E_RD, REG_CONTROL, 0);
        add(E_TX, 0, 0);
        limit = tab_kind.size() * 200;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (tab_kind[i]) begin
            case (tab_kind[i])
                E_RD: begin
                    wb_access(1'b0, tab_arg[i], 0, rdata);
                    check("wb_dat_o", rdata, tab_exp[i]);
                end
                E_WR: wb_access(1'b1, tab_arg[i], tab_exp[i], rdata);
                E_TX: send_word(tab_arg[i]);
                E_LOOP: begin
                    // User words must be ignored while looped back
                    repeat (tab_arg[i]) begin
                        txd = random_word();
                        txc = 8'h00;
                        step();
                        check_tx();
                    end
                    txd = {8{XGMII_IDLE}};
                    txc = 8'hFF;
                end
                E_BAD: begin
                    // Lock holds until the last invalid header of the run
                    corrupt = 1'b1;
                    repeat (tab_arg[i] - 1) step();
                    check("block_lock_o", lock, 1);
                    step();
                    corrupt = 1'b0;
                    check("block_lock_o", lock, tab_exp[i]);
                end
                default: wait_lock(tab_exp[i][0]);
            endcase
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== eth_pcs.f ====
src/eth_pcs_pkg.sv
src/pcs_csr_if.sv
src/pcs_tx_encoder.sv
src/pcs_scrambler.sv
src/pcs_rx_block_lock.sv
src/pcs_descrambler.sv
src/pcs_rx_decoder.sv
src/pcs_csr.sv
src/eth_pcs_top.sv
bench/eth_pcs_tb.sv

// ==== src/eth_pcs_pkg.sv ====
// Shared constants, block types and register map of the 10GBASE-R PCS, imported by every stage
package eth_pcs_pkg;

    // Sync headers, never scrambled
    localparam logic [1:0] HDR_DATA = 2'b01;
    localparam logic [1:0] HDR_CTRL = 2'b10;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    // 7-bit lane codes inside a control block
    localparam logic [6:0] PCS_IDLE_CODE  = 7'h00;
    localparam logic [6:0] PCS_ERROR_CODE = 7'h1E;

    // Block type field in payload bits 7:0
    typedef enum logic [7:0] {
        BT_CTRL_ONLY = 8'h1E
    } block_type_e;

    // Wishbone byte addresses
    typedef enum logic [7:0] {
        REG_ID        = 8'h00,
        REG_STATUS    = 8'h04,
        REG_CONTROL   = 8'h08,
        REG_ERR_COUNT = 8'h0C
    } pcs_reg_e;

    // Presence marker read back at REG_ID
    localparam logic [31:0] PCS_ID_VALUE = 32'h0000_0001;

    // Scrambler state length for x^58 + x^39 + 1
    localparam int SCR_WIDTH = 58;

    // Block lock thresholds
    localparam logic [6:0] LOCK_GOOD_COUNT = 7'd64;
    localparam logic [4:0] LOCK_BAD_COUNT  = 5'd16;

    // Register bit positions
    localparam int CTRL_PCS_RESET_BIT = 0;
    localparam int CTRL_LOOPBACK_BIT  = 1;
    localparam int STATUS_LOCK_BIT    = 0;

endpackage

// ==== src/eth_pcs_top.sv ====
// 10GBASE-R PCS top level joining TX and RX stages to the Wishbone register block
`timescale 1ns/1ps

module eth_pcs_top (
    input  logic        wb_i,
    input  logic        arst_n_i,
    // Wishbone slave
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [7:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    // XGMII transmit
    input  logic [63:0] xgmii_txd_i,
    input  logic [7:0]  xgmii_txc_i,
    // Serdes side, header and payload aligned
    output logic [1:0]  serdes_tx_hdr_o,
    output logic [63:0] serdes_tx_payload_o,
    input  logic [1:0]  serdes_rx_hdr_i,
    input  logic [63:0] serdes_rx_payload_i,
    // XGMII receive
    output logic [63:0] xgmii_rxd_o,
    output logic [7:0]  xgmii_rxc_o,
    output logic        block_lock_o
);

    pcs_csr_if csr_bus ();

    logic [1:0]  enc_hdr;
    logic [63:0] enc_payload;
    logic [1:0]  lock_hdr;
    logic [63:0] lock_payload;
    logic [1:0]  dsc_hdr;
    logic [63:0] dsc_payload;

    pcs_csr u_csr (
        .wb_i     (wb_i),
        .arst_n_i (arst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .csr      (csr_bus)
    );

    // Decoder output doubles as the loopback source
    pcs_tx_encoder u_tx_encoder (
        .wb_i         (wb_i),
        .arst_n_i     (arst_n_i),
        .xgmii_txd_i  (xgmii_txd_i),
        .xgmii_txc_i  (xgmii_txc_i),
        .xgmii_lbd_i  (xgmii_rxd_o),
        .xgmii_lbc_i  (xgmii_rxc_o),
        .csr          (csr_bus),
        .tx_hdr_o     (enc_hdr),
        .tx_payload_o (enc_payload)
    );

    pcs_scrambler u_scrambler (
        .wb_i      (wb_i),
        .arst_n_i  (arst_n_i),
        .csr       (csr_bus),
        .hdr_i     (enc_hdr),
        .payload_i (enc_payload),
        .hdr_o     (serdes_tx_hdr_o),
        .payload_o (serdes_tx_payload_o)
    );

    pcs_rx_block_lock u_rx_block_lock (
        .wb_i                (wb_i),
        .arst_n_i            (arst_n_i),
        .csr_stat            (csr_bus),
        .csr_dp              (csr_bus),
        .serdes_rx_hdr_i     (serdes_rx_hdr_i),
        .serdes_rx_payload_i (serdes_rx_payload_i),
        .hdr_o               (lock_hdr),
        .payload_o           (lock_payload)
    );

    pcs_descrambler u_descrambler (
        .wb_i      (wb_i),
        .arst_n_i  (arst_n_i),
        .csr       (csr_bus),
        .hdr_i     (lock_hdr),
        .payload_i (lock_payload),
        .hdr_o     (dsc_hdr),
        .payload_o (dsc_payload)
    );

    pcs_rx_decoder u_rx_decoder (
        .wb_i        (wb_i),
        .arst_n_i    (arst_n_i),
        .csr_stat    (csr_bus),
        .csr_dp      (csr_bus),
        .hdr_i       (dsc_hdr),
        .payload_i   (dsc_payload),
        .xgmii_rxd_o (xgmii_rxd_o),
        .xgmii_rxc_o (xgmii_rxc_o)
    );

    assign block_lock_o = csr_bus.block_lock;

endmodule

// ==== src/pcs_csr.sv ====
// Wishbone register block with ID, status, control and errored-block counter
`timescale 1ns/1ps

module pcs_csr (
    input  logic        wb_i,
    input  logic        arst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [7:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    pcs_csr_if.csr      csr
);
    import eth_pcs_pkg::*;

    logic [7:0]  reg_adr;
    logic        req;
    logic [1:0]  ctrl_q;
    logic [15:0] err_cnt_q;
    logic [31:0] status;

    // Word address, byte lanes ignored
    assign reg_adr = {wb_adr_i[7:2], 2'b00};
    assign req     = wb_cyc_i && wb_stb_i;

    always_comb begin
        status                  = '0;
        status[STATUS_LOCK_BIT] = csr.block_lock;
    end

    always_ff @(posedge wb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
            ctrl_q   <= '0;
        end else if (csr.pcs_reset) begin
            // PCS reset bit clears itself after one cycle
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
            ctrl_q   <= '0;
        end else begin
            wb_ack_o <= req;
            wb_dat_o <= '0;
            if (req && wb_we_i) begin
                if (reg_adr == REG_CONTROL) begin
                    ctrl_q <= wb_dat_i[1:0];
                end
            end else if (req) begin
                case (reg_adr)
                    REG_ID:        wb_dat_o <= PCS_ID_VALUE;
                    REG_STATUS:    wb_dat_o <= status;
                    REG_CONTROL:   wb_dat_o <= {30'd0, ctrl_q};
                    REG_ERR_COUNT: wb_dat_o <= {16'd0, err_cnt_q};
                    default:       wb_dat_o <= '0;
                endcase
            end
        end
    end

    // Saturating count of errored blocks, any write clears it
    always_ff @(posedge wb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_cnt_q <= '0;
        end else if (req && wb_we_i && reg_adr == REG_ERR_COUNT) begin
            err_cnt_q <= '0;
        end else if (csr.err_block && err_cnt_q != 16'hFFFF) begin
            err_cnt_q <= err_cnt_q + 16'd1;
        end
    end

    assign csr.pcs_reset = ctrl_q[CTRL_PCS_RESET_BIT];
    assign csr.loopback  = ctrl_q[CTRL_LOOPBACK_BIT];

    // Every ack answers a request sampled one edge earlier
    a_ack_after_req: assert property (
        @(posedge wb_i) disable iff (!arst_n_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)
    ) else $error("wishbone ack without request");

endmodule

// ==== src/pcs_csr_if.sv ====
// Control and status levels between the register block and the PCS datapath stages
`timescale 1ns/1ps

interface pcs_csr_if;

    // Driven by the register block
    logic pcs_reset;
    logic loopback;

    // Driven by the receive datapath
    logic block_lock;
    logic err_block;

    // Register block side
    modport csr (
        output pcs_reset,
        output loopback,
        input  block_lock,
        input  err_block
    );

    // Status producers in the receive path
    modport stat (
        output block_lock,
        output err_block
    );

    // Datapath consumers of the control levels
    modport dp (
        input pcs_reset,
        input loopback,
        input block_lock
    );

endinterface

// ==== src/pcs_descrambler.sv ====
// Receive self-synchronizing descrambler, between block lock and the decoder
`timescale 1ns/1ps

module pcs_descrambler (
    input  logic        wb_i,
    input  logic        arst_n_i,
    pcs_csr_if.dp       csr,
    input  logic [1:0]  hdr_i,
    input  logic [63:0] payload_i,
    output logic [1:0]  hdr_o,
    output logic [63:0] payload_o
);
    import eth_pcs_pkg::*;

    logic [SCR_WIDTH-1:0] state_q;
    logic [SCR_WIDTH-1:0] state_d;
    logic [63:0]          dsc_d;

    // Received line bits feed the state, so it resyncs after 58 bits
    always_comb begin
        state_d = state_q;
        for (int i = 0; i < 64; i++) begin
            dsc_d[i] = payload_i[i] ^ state_d[38] ^ state_d[SCR_WIDTH-1];
            state_d  = {state_d[SCR_WIDTH-2:0], payload_i[i]};
        end
    end

    always_ff @(posedge wb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= '1;
            hdr_o   <= 2'b00;
        end else if (csr.pcs_reset) begin
            state_q <= '1;
            hdr_o   <= 2'b00;
        end else begin
            state_q <= state_d;
            hdr_o   <= hdr_i;
        end
    end

    always_ff @(posedge wb_i) begin
        payload_o <= dsc_d;
    end

endmodule

// ==== src/pcs_rx_block_lock.sv ====
// Receive input register with sync header check and block lock tracking
`timescale 1ns/1ps

module pcs_rx_block_lock (
    input  logic        wb_i,
    input  logic        arst_n_i,
    pcs_csr_if.stat     csr_stat,
    pcs_csr_if.dp       csr_dp,
    input  logic [1:0]  serdes_rx_hdr_i,
    input  logic [63:0] serdes_rx_payload_i,
    output logic [1:0]  hdr_o,
    output logic [63:0] payload_o
);
    import eth_pcs_pkg::*;

    logic       hdr_valid;
    logic [6:0] good_cnt_q;
    logic [4:0] bad_cnt_q;
    logic       lock_q;

    // Only 01 and 10 are legal sync headers
    assign hdr_valid = (serdes_rx_hdr_i == HDR_DATA) || (serdes_rx_hdr_i == HDR_CTRL);

    always_ff @(posedge wb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hdr_o      <= 2'b00;
            good_cnt_q <= '0;
            bad_cnt_q  <= '0;
            lock_q     <= 1'b0;
        end else if (csr_dp.pcs_reset) begin
            hdr_o      <= 2'b00;
            good_cnt_q <= '0;
            bad_cnt_q  <= '0;
            lock_q     <= 1'b0;
        end else begin
            hdr_o <= serdes_rx_hdr_i;
            if (hdr_valid) begin
                if (good_cnt_q == LOCK_GOOD_COUNT - 7'd1) begin
                    // Full good run, gain lock or forgive earlier bad headers
                    good_cnt_q <= '0;
                    bad_cnt_q  <= '0;
                    lock_q     <= 1'b1;
                end else begin
                    good_cnt_q <= good_cnt_q + 7'd1;
                end
            end else begin
                good_cnt_q <= '0;
                if (lock_q) begin
                    if (bad_cnt_q == LOCK_BAD_COUNT - 5'd1) begin
                        bad_cnt_q <= '0;
                        lock_q    <= 1'b0;
                    end else begin
                        bad_cnt_q <= bad_cnt_q + 5'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge wb_i) begin
        payload_o <= serdes_rx_payload_i;
    end

    assign csr_stat.block_lock = lock_q;

    // Lock is gained only on the last header of a valid run
    a_lock_on_valid: assert property (
        @(posedge wb_i) disable iff (!arst_n_i)
        $rose(lock_q) |-> (hdr_o == HDR_DATA || hdr_o == HDR_CTRL)
    ) else $error("block lock rose on an invalid header");

endmodule

// ==== src/pcs_rx_decoder.sv ====
// Receive 64b/66b decoder back to XGMII, last stage of the RX path, flags errored blocks
`timescale 1ns/1ps

module pcs_rx_decoder (
    input  logic        wb_i,
    input  logic        arst_n_i,
    pcs_csr_if.stat     csr_stat,
    pcs_csr_if.dp       csr_dp,
    input  logic [1:0]  hdr_i,
    input  logic [63:0] payload_i,
    output logic [63:0] xgmii_rxd_o,
    output logic [7:0]  xgmii_rxc_o
);
    import eth_pcs_pkg::*;

    logic [63:0] dec_d;
    logic [7:0]  dec_c;
    logic        dec_err;
    logic        err_q;

    always_comb begin
        // Unknown header or block type gives an all-error word
        dec_d   = {8{XGMII_ERROR}};
        dec_c   = 8'hFF;
        dec_err = 1'b1;

        if (hdr_i == HDR_DATA) begin
            dec_d   = payload_i;
            dec_c   = 8'h00;
            dec_err = 1'b0;
        end else if (hdr_i == HDR_CTRL && payload_i[7:0] == BT_CTRL_ONLY) begin
            dec_err = 1'b0;
            for (int i = 0; i < 8; i++) begin
                if (payload_i[8 + 7*i +: 7] == PCS_IDLE_CODE) begin
                    dec_d[8*i +: 8] = XGMII_IDLE;
                end else begin
                    // Any non-idle lane counts as an errored block
                    dec_d[8*i +: 8] = XGMII_ERROR;
                    dec_err         = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge wb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            xgmii_rxd_o <= {8{XGMII_IDLE}};
            xgmii_rxc_o <= 8'hFF;
            err_q       <= 1'b0;
        end else if (csr_dp.pcs_reset || !csr_dp.block_lock) begin
            // No lock, send idles and stay quiet
            xgmii_rxd_o <= {8{XGMII_IDLE}};
            xgmii_rxc_o <= 8'hFF;
            err_q       <= 1'b0;
        end else begin
            xgmii_rxd_o <= dec_d;
            xgmii_rxc_o <= dec_c;
            err_q       <= dec_err;
        end
    end

    // One pulse per errored block
    assign csr_stat.err_block = err_q;

endmodule

// ==== src/pcs_scrambler.sv ====
// Transmit scrambler for x^58 + x^39 + 1, second and last stage of the TX path
`timescale 1ns/1ps

module pcs_scrambler (
    input  logic        wb_i,
    input  logic        arst_n_i,
    pcs_csr_if.dp       csr,
    input  logic [1:0]  hdr_i,
    input  logic [63:0] payload_i,
    output logic [1:0]  hdr_o,
    output logic [63:0] payload_o
);
    import eth_pcs_pkg::*;

    logic [SCR_WIDTH-1:0] state_q;
    logic [SCR_WIDTH-1:0] state_d;
    logic [63:0]          scr_d;

    // Bit 0 first, state[0] holds the most recent scrambled bit
    always_comb begin
        state_d = state_q;
        for (int i = 0; i < 64; i++) begin
            // Taps 39 and 58 bits back
            scr_d[i] = payload_i[i] ^ state_d[38] ^ state_d[SCR_WIDTH-1];
            state_d  = {state_d[SCR_WIDTH-2:0], scr_d[i]};
        end
    end

    always_ff @(posedge wb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= '1;
            hdr_o   <= HDR_CTRL;
        end else if (csr.pcs_reset) begin
            state_q <= '1;
            hdr_o   <= HDR_CTRL;
        end else begin
            state_q <= state_d;
            hdr_o   <= hdr_i;
        end
    end

    // Payload follows the header with the same delay
    always_ff @(posedge wb_i) begin
        payload_o <= scr_d;
    end

    // The encoder must never hand over an illegal sync header
    a_tx_hdr_legal: assert property (
        @(posedge wb_i) disable iff (!arst_n_i)
        hdr_o == HDR_DATA || hdr_o == HDR_CTRL
    ) else $error("illegal TX sync header %b", hdr_o);

endmodule

// ==== src/pcs_tx_encoder.sv ====
// Transmit 64b/66b encoder with XGMII loopback select, first stage of the TX path
`timescale 1ns/1ps

module pcs_tx_encoder (
    input  logic        wb_i,
    input  logic        arst_n_i,
    input  logic [63:0] xgmii_txd_i,
    input  logic [7:0]  xgmii_txc_i,
    input  logic [63:0] xgmii_lbd_i,
    input  logic [7:0]  xgmii_lbc_i,
    pcs_csr_if.dp       csr,
    output logic [1:0]  tx_hdr_o,
    output logic [63:0] tx_payload_o
);
    import eth_pcs_pkg::*;

    logic [63:0] src_d;
    logic [7:0]  src_c;
    logic        all_idle;
    logic [1:0]  enc_hdr;
    logic [63:0] enc_payload;

    // Loopback takes the decoded RX word in place of the user word
    assign src_d = csr.loopback ? xgmii_lbd_i : xgmii_txd_i;
    assign src_c = csr.loopback ? xgmii_lbc_i : xgmii_txc_i;

    always_comb begin
        all_idle = 1'b1;
        for (int i = 0; i < 8; i++) begin
            if (src_d[8*i +: 8] != XGMII_IDLE) begin
                all_idle = 1'b0;
            end
        end

        // Default is a control block full of error codes
        enc_hdr           = HDR_CTRL;
        enc_payload[7:0]  = BT_CTRL_ONLY;
        enc_payload[63:8] = {8{PCS_ERROR_CODE}};

        if (src_c == 8'h00) begin
            // Plain data passes unchanged
            enc_hdr     = HDR_DATA;
            enc_payload = src_d;
        end else if (src_c == 8'hFF && all_idle) begin
            enc_payload[63:8] = {8{PCS_IDLE_CODE}};
        end
    end

    // Reset and PCS reset both leave an idle block on the line
    always_ff @(posedge wb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_hdr_o     <= HDR_CTRL;
            tx_payload_o <= {{8{PCS_IDLE_CODE}}, BT_CTRL_ONLY};
        end else if (csr.pcs_reset) begin
            tx_hdr_o     <= HDR_CTRL;
            tx_payload_o <= {{8{PCS_IDLE_CODE}}, BT_CTRL_ONLY};
        end else begin
            tx_hdr_o     <= enc_hdr;
            tx_payload_o <= enc_payload;
        end
    end

endmodule
